/* cache_defines.svh */
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// word width, also the byte address width
`define XLEN 32

// line geometry
`define LINE_WORDS 4
`define NUM_SETS 64

// victim store depth
`define VC_ENTRIES 4

// backing store size in words, line read latency in cycles
`define MEM_WORDS 4096
`define MEM_LATENCY 4

// word select inside a line, set select
`define OFFSET_BITS 2
`define INDEX_BITS 6

// everything above bit 10 of the byte address
`define TAG_BITS (`XLEN - `INDEX_BITS - `OFFSET_BITS - 2)

// one full line in bits
`define LINE_BITS (`XLEN * `LINE_WORDS)

`endif

/* cache_pkg.sv */
`include "cache_defines.svh"

package cache_pkg;

	// plain vectors
	typedef logic [`XLEN-1:0] word_t;
	typedef logic [`XLEN-1:0] addr_t;
	typedef logic [`TAG_BITS-1:0] tag_t;
	typedef logic [`LINE_BITS-1:0] line_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [1:0] wb_sel_t;

	// core side, word access
	typedef struct packed {
		addr_t addr;
		word_t data;
		logic  rw;
		logic  valid;
	} cpu_req_t;

	typedef struct packed {
		word_t data;
		logic  ready;
	} cpu_res_t;

	// memory side, whole lines; addr is line aligned
	typedef struct packed {
		addr_t addr;
		line_t data;
		logic  rw;
		logic  valid;
	} mem_req_t;

	typedef struct packed {
		line_t data;
		logic  ready;
	} mem_data_t;

	// replaced line on its way to the victim store
	typedef struct packed {
		line_t                  data;
		tag_t                   tag;
		logic [`INDEX_BITS-1:0] index;
		logic                   dirty;
		logic                   valid;
	} evict_t;

	// line handed back by the victim store
	typedef struct packed {
		line_t data;
		logic  dirty;
		logic  hit;
	} swap_t;

	typedef enum logic [1:0] {
		IDLE,
		VC_LOOKUP,
		WRITE_BACK,
		ALLOCATE
	} dc_state_e;

endpackage

/* main_memory.sv */
`timescale 1ns/1ps
`include "cache_defines.svh"

module main_memory (
	input  logic                 clk_i,
	input  logic                 rst_ni,
	input  cache_pkg::mem_req_t  mem_req_i,
	input  logic                 wr_valid_i,
	input  cache_pkg::addr_t     wr_addr_i,
	input  cache_pkg::line_t     wr_line_i,
	output cache_pkg::mem_data_t mem_data_o
);

	localparam int WADDR_BITS = $clog2(`MEM_WORDS);
	localparam int CNT_BITS = $clog2(`MEM_LATENCY + 2);
	localparam int LSB = `OFFSET_BITS + 2;

	cache_pkg::word_t mem [`MEM_WORDS];

	logic [CNT_BITS-1:0] cnt_q;
	logic rd_req;
	logic wr_req;
	logic [WADDR_BITS-1:0] line_base;
	logic [WADDR_BITS-1:0] vc_base;

	assign rd_req = mem_req_i.valid & ~mem_req_i.rw;
	assign wr_req = mem_req_i.valid & mem_req_i.rw;

	// word index of the first word in each line
	assign line_base = {mem_req_i.addr[WADDR_BITS+1:LSB], {`OFFSET_BITS{1'b0}}};
	assign vc_base = {wr_addr_i[WADDR_BITS+1:LSB], {`OFFSET_BITS{1'b0}}};

	// cycles since valid rose, stops one past the latency so ready fires once
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			cnt_q <= '0;
		end else if (!rd_req) begin
			cnt_q <= '0;
		end else if (cnt_q <= CNT_BITS'(`MEM_LATENCY)) begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	always_comb begin
		for (int w = 0; w < `LINE_WORDS; w++) begin
			mem_data_o.data[w*`XLEN +: `XLEN] = mem[line_base + WADDR_BITS'(w)];
		end
		mem_data_o.ready = rd_req && (cnt_q == CNT_BITS'(`MEM_LATENCY));
	end

	// cache write-back and victim write-out land at the same edge they arrive
	always_ff @(posedge clk_i) begin
		for (int w = 0; w < `LINE_WORDS; w++) begin
			if (wr_req) begin
				mem[line_base + WADDR_BITS'(w)] <= mem_req_i.data[w*`XLEN +: `XLEN];
			end
			if (wr_valid_i) begin
				mem[vc_base + WADDR_BITS'(w)] <= wr_line_i[w*`XLEN +: `XLEN];
			end
		end
	end

endmodule

/* victim_cache.sv */
`timescale 1ns/1ps
`include "cache_defines.svh"

module victim_cache (
	input  logic                clk_i,
	input  logic                rst_ni,
	input  cache_pkg::evict_t   evict_i,
	input  cache_pkg::mem_req_t lookup_i,
	output cache_pkg::swap_t    swap_o,
	output logic                vc_ready_o,
	output logic                wr_valid_o,
	output cache_pkg::addr_t    wr_addr_o,
	output cache_pkg::line_t    wr_line_o
);

	localparam int PTR_BITS = $clog2(`VC_ENTRIES);
	localparam int LSB = `OFFSET_BITS + 2;

	// entry storage, addresses kept line aligned
	cache_pkg::line_t ent_line [`VC_ENTRIES];
	cache_pkg::addr_t ent_addr [`VC_ENTRIES];
	logic [`VC_ENTRIES-1:0] ent_valid_q;
	logic [`VC_ENTRIES-1:0] ent_dirty_q;
	logic [PTR_BITS-1:0] ptr_q;

	logic [`VC_ENTRIES-1:0] match;
	logic [PTR_BITS-1:0] hit_idx;
	logic [PTR_BITS-1:0] free_idx;
	logic [PTR_BITS-1:0] ins_idx;
	logic any_free;
	logic lookup_on;
	logic full_ins;
	cache_pkg::addr_t ev_addr;

	// overflow line waiting one cycle for the memory write port
	logic wb_pend_q;
	cache_pkg::addr_t wb_addr_q;
	cache_pkg::line_t wb_line_q;

	// only a line read counts as a lookup
	assign lookup_on = lookup_i.valid & ~lookup_i.rw;

	always_comb begin
		hit_idx = '0;
		free_idx = '0;
		any_free = 1'b0;
		for (int i = 0; i < `VC_ENTRIES; i++) begin
			match[i] = ent_valid_q[i] && (ent_addr[i] == lookup_i.addr);
			if (match[i]) begin
				hit_idx = PTR_BITS'(i);
			end
			// lowest free slot wins
			if (!ent_valid_q[i] && !any_free) begin
				free_idx = PTR_BITS'(i);
				any_free = 1'b1;
			end
		end
	end

	assign swap_o.hit = lookup_on & (|match);
	assign swap_o.data = ent_line[hit_idx];
	assign swap_o.dirty = ent_dirty_q[hit_idx];

	// free slot first, otherwise the oldest under the pointer
	assign ins_idx = any_free ? free_idx : ptr_q;
	assign full_ins = evict_i.valid & ~any_free;
	assign ev_addr = {evict_i.tag, evict_i.index, {LSB{1'b0}}};

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			ent_valid_q <= '0;
			ent_dirty_q <= '0;
			ptr_q <= '0;
			wb_pend_q <= 1'b0;
		end else begin
			// a clean overflow line is simply dropped
			wb_pend_q <= full_ins & ent_dirty_q[ptr_q];
			// line moves back into the cache
			if (swap_o.hit) begin
				ent_valid_q[hit_idx] <= 1'b0;
			end
			if (evict_i.valid) begin
				ent_valid_q[ins_idx] <= 1'b1;
				ent_dirty_q[ins_idx] <= evict_i.dirty;
				if (!any_free) begin
					ptr_q <= ptr_q + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (evict_i.valid) begin
			ent_line[ins_idx] <= evict_i.data;
			ent_addr[ins_idx] <= ev_addr;
		end
		// grab the old entry before it is overwritten
		if (full_ins) begin
			wb_addr_q <= ent_addr[ptr_q];
			wb_line_q <= ent_line[ptr_q];
		end
	end

	assign wr_valid_o = wb_pend_q;
	assign wr_addr_o = wb_addr_q;
	assign wr_line_o = wb_line_q;
	// no new evict while the write-out is on the port
	assign vc_ready_o = ~wb_pend_q;

endmodule

/* d_cache.sv */
`timescale 1ns/1ps
`include "cache_defines.svh"

module d_cache (
	input  logic                 clk_i,
	input  logic                 rst_ni,
	input  cache_pkg::cpu_req_t  cpu_req_i,
	input  cache_pkg::mem_data_t mem_data_i,
	input  cache_pkg::swap_t     swap_i,
	input  logic                 vc_ready_i,
	output cache_pkg::evict_t    evict_o,
	output cache_pkg::cpu_res_t  cpu_res_o,
	output cache_pkg::mem_req_t  mem_req_o,
	output cache_pkg::word_t     no_acc_o,
	output cache_pkg::word_t     no_hit_o,
	output cache_pkg::word_t     no_miss_o
);

	// byte offset plus word offset
	localparam int LSB = `OFFSET_BITS + 2;

	cache_pkg::dc_state_e state_q;
	cache_pkg::dc_state_e state_d;

	// arrays, one entry per set
	cache_pkg::tag_t tag_arr [`NUM_SETS];
	cache_pkg::line_t line_arr [`NUM_SETS];
	logic [`NUM_SETS-1:0] valid_q;
	logic [`NUM_SETS-1:0] dirty_q;

	// line address of the miss being served
	cache_pkg::addr_t miss_addr_q;
	logic missed_q;

	cache_pkg::word_t acc_q;
	cache_pkg::word_t hit_q;
	cache_pkg::word_t miss_q;

	logic [`INDEX_BITS-1:0] req_idx;
	logic [`INDEX_BITS-1:0] miss_idx;
	logic [`OFFSET_BITS-1:0] req_off;
	cache_pkg::tag_t req_tag;
	cache_pkg::tag_t miss_tag;
	logic hit;
	logic miss;

	// address split
	assign req_idx = cpu_req_i.addr[LSB +: `INDEX_BITS];
	assign req_off = cpu_req_i.addr[2 +: `OFFSET_BITS];
	assign req_tag = cpu_req_i.addr[`XLEN-1 -: `TAG_BITS];
	assign miss_idx = miss_addr_q[LSB +: `INDEX_BITS];
	assign miss_tag = miss_addr_q[`XLEN-1 -: `TAG_BITS];

	assign hit = cpu_req_i.valid & valid_q[req_idx] & (tag_arr[req_idx] == req_tag);
	assign miss = (state_q == cache_pkg::IDLE) & cpu_req_i.valid & ~hit;

	// hits answer in the request cycle
	assign cpu_res_o.ready = (state_q == cache_pkg::IDLE) & hit;
	assign cpu_res_o.data = line_arr[req_idx][req_off*`XLEN +: `XLEN];

	// replaced line goes to the victim store if it can take it
	assign evict_o.valid = miss & valid_q[req_idx] & vc_ready_i;
	assign evict_o.data = line_arr[req_idx];
	assign evict_o.tag = tag_arr[req_idx];
	assign evict_o.index = req_idx;
	assign evict_o.dirty = dirty_q[req_idx];

	always_comb begin
		state_d = state_q;
		unique case (state_q)
			cache_pkg::IDLE: begin
				if (miss) begin
					// victim store busy with a write-out, go around it
					if (valid_q[req_idx] && !vc_ready_i) begin
						state_d = cache_pkg::WRITE_BACK;
					end else begin
						state_d = cache_pkg::VC_LOOKUP;
					end
				end
			end
			cache_pkg::WRITE_BACK: begin
				state_d = cache_pkg::VC_LOOKUP;
			end
			cache_pkg::VC_LOOKUP: begin
				state_d = swap_i.hit ? cache_pkg::IDLE : cache_pkg::ALLOCATE;
			end
			cache_pkg::ALLOCATE: begin
				if (mem_data_i.ready) begin
					state_d = cache_pkg::IDLE;
				end
			end
			default: begin
				state_d = cache_pkg::IDLE;
			end
		endcase
	end

	// read valid stays up from the lookup through the fill,
	// so memory latency runs in parallel with the victim check
	always_comb begin
		mem_req_o.addr = miss_addr_q;
		mem_req_o.data = line_arr[miss_idx];
		mem_req_o.rw = 1'b0;
		mem_req_o.valid = 1'b0;
		unique case (state_q)
			cache_pkg::WRITE_BACK: begin
				mem_req_o.addr = {tag_arr[miss_idx], miss_idx, {LSB{1'b0}}};
				mem_req_o.rw = 1'b1;
				// clean line needs no write
				mem_req_o.valid = dirty_q[miss_idx];
			end
			cache_pkg::VC_LOOKUP,
			cache_pkg::ALLOCATE: begin
				mem_req_o.valid = 1'b1;
			end
			default: begin
				mem_req_o.valid = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= cache_pkg::IDLE;
			valid_q <= '0;
			dirty_q <= '0;
			miss_addr_q <= '0;
			missed_q <= 1'b0;
			acc_q <= '0;
			hit_q <= '0;
			miss_q <= '0;
		end else begin
			state_q <= state_d;
			// write hit marks the line dirty
			if (cpu_res_o.ready && cpu_req_i.rw) begin
				dirty_q[req_idx] <= 1'b1;
			end
			// the old line leaves the set as the miss starts
			if (miss) begin
				valid_q[req_idx] <= 1'b0;
				miss_addr_q <= {cpu_req_i.addr[`XLEN-1:LSB], {LSB{1'b0}}};
				missed_q <= 1'b1;
			end else if (state_q == cache_pkg::IDLE && !cpu_req_i.valid) begin
				// request withdrawn
				missed_q <= 1'b0;
			end
			if (state_q == cache_pkg::VC_LOOKUP && swap_i.hit) begin
				valid_q[miss_idx] <= 1'b1;
				dirty_q[miss_idx] <= swap_i.dirty;
			end
			if (state_q == cache_pkg::ALLOCATE && mem_data_i.ready) begin
				valid_q[miss_idx] <= 1'b1;
				dirty_q[miss_idx] <= 1'b0;
			end
			// one count per completed access
			if (cpu_res_o.ready) begin
				acc_q <= acc_q + 1'b1;
				missed_q <= 1'b0;
				if (missed_q) begin
					miss_q <= miss_q + 1'b1;
				end else begin
					hit_q <= hit_q + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (cpu_res_o.ready && cpu_req_i.rw) begin
			line_arr[req_idx][req_off*`XLEN +: `XLEN] <= cpu_req_i.data;
		end
		if (state_q == cache_pkg::VC_LOOKUP && swap_i.hit) begin
			line_arr[miss_idx] <= swap_i.data;
			tag_arr[miss_idx] <= miss_tag;
		end
		if (state_q == cache_pkg::ALLOCATE && mem_data_i.ready) begin
			line_arr[miss_idx] <= mem_data_i.data;
			tag_arr[miss_idx] <= miss_tag;
		end
	end

	assign no_acc_o = acc_q;
	assign no_hit_o = hit_q;
	assign no_miss_o = miss_q;

endmodule

/* mem_stage.sv */
`timescale 1ns/1ps

module mem_stage (
	input  logic                 clk_i,
	input  logic                 rst_ni,
	input  cache_pkg::addr_t     alu_i,
	input  cache_pkg::word_t     rs2_i,
	input  cache_pkg::word_t     pc4_i,
	input  logic                 mem_rw_i,
	input  cache_pkg::wb_sel_t   wb_sel_i,
	input  logic                 reg_wen_i,
	input  cache_pkg::reg_idx_t  rd_i,
	input  cache_pkg::word_t     inst_i,
	input  logic                 enable_i,
	input  logic                 flush_i,
	input  logic                 mem_valid_i,
	input  logic                 icache_stall_i,
	input  cache_pkg::mem_data_t mem_data_i,
	input  cache_pkg::swap_t     swap_i,
	input  logic                 vc_ready_i,
	output cache_pkg::mem_req_t  mem_req_o,
	output cache_pkg::evict_t    evict_o,
	output cache_pkg::addr_t     alu_o,
	output cache_pkg::word_t     pc4_o,
	output cache_pkg::word_t     mem_o,
	output cache_pkg::wb_sel_t   wb_sel_o,
	output logic                 reg_wen_o,
	output cache_pkg::reg_idx_t  rd_o,
	output cache_pkg::word_t     inst_o,
	output logic                 stall_o,
	output cache_pkg::word_t     no_acc_o,
	output cache_pkg::word_t     no_hit_o,
	output cache_pkg::word_t     no_miss_o
);

	// fields handed to writeback
	typedef struct packed {
		cache_pkg::addr_t    alu;
		cache_pkg::word_t    pc4;
		cache_pkg::word_t    mem;
		cache_pkg::wb_sel_t  wb_sel;
		logic                reg_wen;
		cache_pkg::reg_idx_t rd;
		cache_pkg::word_t    inst;
	} wb_reg_t;

	cache_pkg::cpu_req_t cpu_req;
	cache_pkg::cpu_res_t cpu_res;
	wb_reg_t wb_d;
	wb_reg_t wb_q;

	// access is dropped while fetch is stalled
	assign cpu_req.addr = alu_i;
	assign cpu_req.data = rs2_i;
	assign cpu_req.rw = mem_rw_i;
	assign cpu_req.valid = mem_valid_i & ~icache_stall_i;

	d_cache u_d_cache (
		.clk_i      (clk_i),
		.rst_ni     (rst_ni),
		.cpu_req_i  (cpu_req),
		.mem_data_i (mem_data_i),
		.swap_i     (swap_i),
		.vc_ready_i (vc_ready_i),
		.evict_o    (evict_o),
		.cpu_res_o  (cpu_res),
		.mem_req_o  (mem_req_o),
		.no_acc_o   (no_acc_o),
		.no_hit_o   (no_hit_o),
		.no_miss_o  (no_miss_o)
	);

	// hold earlier stages during a miss or a victim write-out
	assign stall_o = (cpu_req.valid & ~cpu_res.ready) | ~vc_ready_i;

	assign wb_d.alu = alu_i;
	assign wb_d.pc4 = pc4_i;
	assign wb_d.mem = cpu_res.data;
	assign wb_d.wb_sel = wb_sel_i;
	assign wb_d.reg_wen = reg_wen_i;
	assign wb_d.rd = rd_i;
	assign wb_d.inst = inst_i;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			wb_q <= '0;
		end else if (enable_i) begin
			// flush turns the slot into a bubble
			wb_q <= flush_i ? '0 : wb_d;
		end
	end

	assign alu_o = wb_q.alu;
	assign pc4_o = wb_q.pc4;
	assign mem_o = wb_q.mem;
	assign wb_sel_o = wb_q.wb_sel;
	assign reg_wen_o = wb_q.reg_wen;
	assign rd_o = wb_q.rd;
	assign inst_o = wb_q.inst;

endmodule

/* mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top (
	input  logic                clk_i,
	input  logic                rst_ni,
	input  cache_pkg::addr_t    alu_i,
	input  cache_pkg::word_t    rs2_i,
	input  cache_pkg::word_t    pc4_i,
	input  logic                mem_rw_i,
	input  cache_pkg::wb_sel_t  wb_sel_i,
	input  logic                reg_wen_i,
	input  cache_pkg::reg_idx_t rd_i,
	input  cache_pkg::word_t    inst_i,
	input  logic                flush_i,
	input  logic                mem_valid_i,
	input  logic                icache_stall_i,
	output cache_pkg::addr_t    alu_o,
	output cache_pkg::word_t    pc4_o,
	output cache_pkg::word_t    mem_o,
	output cache_pkg::wb_sel_t  wb_sel_o,
	output logic                reg_wen_o,
	output cache_pkg::reg_idx_t rd_o,
	output cache_pkg::word_t    inst_o,
	output logic                stall_o,
	output cache_pkg::word_t    no_acc_o,
	output cache_pkg::word_t    no_hit_o,
	output cache_pkg::word_t    no_miss_o
);

	cache_pkg::mem_req_t mem_req;
	cache_pkg::mem_data_t mem_data;
	cache_pkg::evict_t evict;
	cache_pkg::swap_t swap;
	logic vc_ready;
	// victim write-out path into memory
	logic vc_wr_valid;
	cache_pkg::addr_t vc_wr_addr;
	cache_pkg::line_t vc_wr_line;

	// register waits out the stall
	mem_stage u_mem_stage (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.alu_i          (alu_i),
		.rs2_i          (rs2_i),
		.pc4_i          (pc4_i),
		.mem_rw_i       (mem_rw_i),
		.wb_sel_i       (wb_sel_i),
		.reg_wen_i      (reg_wen_i),
		.rd_i           (rd_i),
		.inst_i         (inst_i),
		.enable_i       (~stall_o),
		.flush_i        (flush_i),
		.mem_valid_i    (mem_valid_i),
		.icache_stall_i (icache_stall_i),
		.mem_data_i     (mem_data),
		.swap_i         (swap),
		.vc_ready_i     (vc_ready),
		.mem_req_o      (mem_req),
		.evict_o        (evict),
		.alu_o          (alu_o),
		.pc4_o          (pc4_o),
		.mem_o          (mem_o),
		.wb_sel_o       (wb_sel_o),
		.reg_wen_o      (reg_wen_o),
		.rd_o           (rd_o),
		.inst_o         (inst_o),
		.stall_o        (stall_o),
		.no_acc_o       (no_acc_o),
		.no_hit_o       (no_hit_o),
		.no_miss_o      (no_miss_o)
	);

	// victim store snoops the miss address on the memory request
	victim_cache u_victim_cache (
		.clk_i      (clk_i),
		.rst_ni     (rst_ni),
		.evict_i    (evict),
		.lookup_i   (mem_req),
		.swap_o     (swap),
		.vc_ready_o (vc_ready),
		.wr_valid_o (vc_wr_valid),
		.wr_addr_o  (vc_wr_addr),
		.wr_line_o  (vc_wr_line)
	);

	main_memory u_main_memory (
		.clk_i      (clk_i),
		.rst_ni     (rst_ni),
		.mem_req_i  (mem_req),
		.wr_valid_i (vc_wr_valid),
		.wr_addr_i  (vc_wr_addr),
		.wr_line_i  (vc_wr_line),
		.mem_data_o (mem_data)
	);

endmodule

/* tb_mem_subsys.sv */
`timescale 1ns/1ps
`include "cache_defines.svh"

module tb_mem_subsys;

	localparam int PERIOD = 40;
	localparam int WADDR_BITS = $clog2(`MEM_WORDS);
	localparam int MAX_WAIT = 100;
	localparam int NUM_RANDOM = 200;
	localparam int unsigned SEED = 32'h2c4aa154;

	// one expected writeback slot, plus the counters right after it
	typedef struct packed {
		cache_pkg::addr_t    alu;
		cache_pkg::word_t    pc4;
		cache_pkg::word_t    mem;
		logic                chk_mem;
		cache_pkg::wb_sel_t  wb_sel;
		logic                reg_wen;
		cache_pkg::reg_idx_t rd;
		cache_pkg::word_t    inst;
		cache_pkg::word_t    acc;
		cache_pkg::word_t    hit;
		cache_pkg::word_t    miss;
	} exp_wb_t;

	logic clk_i;
	logic rst_ni;
	cache_pkg::addr_t alu_i;
	cache_pkg::word_t rs2_i;
	cache_pkg::word_t pc4_i;
	logic mem_rw_i;
	cache_pkg::wb_sel_t wb_sel_i;
	logic reg_wen_i;
	cache_pkg::reg_idx_t rd_i;
	cache_pkg::word_t inst_i;
	logic flush_i;
	logic mem_valid_i;
	logic icache_stall_i;
	cache_pkg::addr_t alu_o;
	cache_pkg::word_t pc4_o;
	cache_pkg::word_t mem_o;
	cache_pkg::wb_sel_t wb_sel_o;
	logic reg_wen_o;
	cache_pkg::reg_idx_t rd_o;
	cache_pkg::word_t inst_o;
	logic stall_o;
	cache_pkg::word_t no_acc_o;
	cache_pkg::word_t no_hit_o;
	cache_pkg::word_t no_miss_o;

	// expected slots, oldest first
	exp_wb_t exp_q [$];

	// reference state: word image, written flags, tag store
	cache_pkg::word_t image [`MEM_WORDS];
	logic [`MEM_WORDS-1:0] known;
	cache_pkg::tag_t model_tag [`NUM_SETS];
	logic [`NUM_SETS-1:0] model_valid;

	int exp_acc;
	int exp_hit;
	int exp_miss;
	int errors;
	int tests_run;
	int tests_failed;
	logic timed_out;

	mem_subsys_top dut_i (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.alu_i          (alu_i),
		.rs2_i          (rs2_i),
		.pc4_i          (pc4_i),
		.mem_rw_i       (mem_rw_i),
		.wb_sel_i       (wb_sel_i),
		.reg_wen_i      (reg_wen_i),
		.rd_i           (rd_i),
		.inst_i         (inst_i),
		.flush_i        (flush_i),
		.mem_valid_i    (mem_valid_i),
		.icache_stall_i (icache_stall_i),
		.alu_o          (alu_o),
		.pc4_o          (pc4_o),
		.mem_o          (mem_o),
		.wb_sel_o       (wb_sel_o),
		.reg_wen_o      (reg_wen_o),
		.rd_o           (rd_o),
		.inst_o         (inst_o),
		.stall_o        (stall_o),
		.no_acc_o       (no_acc_o),
		.no_hit_o       (no_hit_o),
		.no_miss_o      (no_miss_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #(PERIOD / 2) clk_i = ~clk_i;
	end

	// flat word image, a store updates it, returns the word a load must see
	function automatic cache_pkg::word_t mem_model(input cache_pkg::addr_t a, input logic rw,
		input cache_pkg::word_t d);
		int w;
		w = int'(a[WADDR_BITS+1:2]);
		if (rw) begin
			image[w] = d;
			known[w] = 1'b1;
		end
		return image[w];
	endfunction

	// direct mapped: hit when the set holds the same tag
	function automatic logic tag_model(input cache_pkg::addr_t a);
		logic [`INDEX_BITS-1:0] idx;
		cache_pkg::tag_t tag;
		logic hit;
		idx = a[`OFFSET_BITS+2 +: `INDEX_BITS];
		tag = a[`XLEN-1 -: `TAG_BITS];
		hit = model_valid[idx] && (model_tag[idx] == tag);
		// after any access the set holds this line
		model_valid[idx] = 1'b1;
		model_tag[idx] = tag;
		return hit;
	endfunction

	// pass-through fields straight from what was driven
	function automatic exp_wb_t capture_expected();
		exp_wb_t e;
		e = '0;
		e.alu = alu_i;
		e.pc4 = pc4_i;
		e.wb_sel = wb_sel_i;
		e.reg_wen = reg_wen_i;
		e.rd = rd_i;
		e.inst = inst_i;
		e.acc = cache_pkg::word_t'(exp_acc);
		e.hit = cache_pkg::word_t'(exp_hit);
		e.miss = cache_pkg::word_t'(exp_miss);
		return e;
	endfunction

	task automatic drive_fields();
		pc4_i = $urandom;
		inst_i = $urandom;
		rd_i = 5'($urandom);
		wb_sel_i = 2'($urandom);
		reg_wen_i = 1'($urandom);
	endtask

	// a stuck DUT fails the run, later accesses are skipped
	task automatic record_timeout(input string what);
		$display("timeout: %s", what);
		timed_out = 1'b1;
		errors++;
	endtask

	task automatic report_test(input string name, input int err0);
		tests_run++;
		if (errors == err0) begin
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - err0);
		end
	endtask

	// one load or store, held until the stage stops stalling
	task automatic run_access(input cache_pkg::addr_t a, input logic rw,
		input cache_pkg::word_t d);
		exp_wb_t e;
		int cycles;
		if (timed_out) begin
			return;
		end
		@(negedge clk_i);
		drive_fields();
		alu_i = a;
		rs2_i = d;
		mem_rw_i = rw;
		mem_valid_i = 1'b1;
		exp_acc++;
		if (tag_model(a)) begin
			exp_hit++;
		end else begin
			exp_miss++;
		end
		e = capture_expected();
		e.mem = mem_model(a, rw, d);
		// load data only matters for words written earlier
		e.chk_mem = !rw && known[a[WADDR_BITS+1:2]];
		cycles = 0;
		#(PERIOD / 4);
		while (stall_o && cycles < MAX_WAIT) begin
			@(negedge clk_i);
			#(PERIOD / 4);
			cycles++;
		end
		if (stall_o) begin
			record_timeout($sformatf("access to %h still stalled after %0d cycles",
				a, MAX_WAIT));
		end else begin
			// register takes the slot here
			@(posedge clk_i);
			exp_q.push_back(e);
		end
		@(negedge clk_i);
		mem_valid_i = 1'b0;
		mem_rw_i = 1'b0;
	endtask

	task automatic drain_checks();
		int cycles;
		cycles = 0;
		while (exp_q.size() > 0 && cycles < MAX_WAIT) begin
			@(negedge clk_i);
			cycles++;
		end
		if (exp_q.size() > 0) begin
			record_timeout("expected results were never compared");
			exp_q.delete();
		end
	endtask

	// outputs are registered, so the falling edge sees them settled
	initial begin : compare_proc
		exp_wb_t e;
		forever begin
			@(negedge clk_i);
			if (exp_q.size() > 0) begin
				e = exp_q.pop_front();
				if (alu_o !== e.alu) begin
					$display("ERROR t=%0t alu_o: got %h expected %h", $time, alu_o, e.alu);
					errors++;
				end
				if (pc4_o !== e.pc4) begin
					$display("ERROR t=%0t pc4_o: got %h expected %h", $time, pc4_o, e.pc4);
					errors++;
				end
				if (e.chk_mem && mem_o !== e.mem) begin
					$display("ERROR t=%0t mem_o: got %h expected %h", $time, mem_o, e.mem);
					errors++;
				end
				if (wb_sel_o !== e.wb_sel) begin
					$display("ERROR t=%0t wb_sel_o: got %h expected %h", $time, wb_sel_o,
						e.wb_sel);
					errors++;
				end
				if (reg_wen_o !== e.reg_wen) begin
					$display("ERROR t=%0t reg_wen_o: got %b expected %b", $time, reg_wen_o,
						e.reg_wen);
					errors++;
				end
				if (rd_o !== e.rd) begin
					$display("ERROR t=%0t rd_o: got %h expected %h", $time, rd_o, e.rd);
					errors++;
				end
				if (inst_o !== e.inst) begin
					$display("ERROR t=%0t inst_o: got %h expected %h", $time, inst_o, e.inst);
					errors++;
				end
				if (no_acc_o !== e.acc) begin
					$display("ERROR t=%0t no_acc_o: got %0d expected %0d", $time, no_acc_o,
						e.acc);
					errors++;
				end
				if (no_hit_o !== e.hit) begin
					$display("ERROR t=%0t no_hit_o: got %0d expected %0d", $time, no_hit_o,
						e.hit);
					errors++;
				end
				if (no_miss_o !== e.miss) begin
					$display("ERROR t=%0t no_miss_o: got %0d expected %0d", $time, no_miss_o,
						e.miss);
					errors++;
				end
			end
		end
	end

	initial begin : main_proc
		int err0;
		int acc0;
		int hit0;
		cache_pkg::addr_t a;
		exp_wb_t e;
		void'($urandom(SEED));
		rst_ni = 1'b0;
		alu_i = '0;
		rs2_i = '0;
		pc4_i = '0;
		mem_rw_i = 1'b0;
		wb_sel_i = '0;
		reg_wen_i = 1'b0;
		rd_i = '0;
		inst_i = '0;
		flush_i = 1'b0;
		mem_valid_i = 1'b0;
		icache_stall_i = 1'b0;
		known = '0;
		model_valid = '0;
		exp_acc = 0;
		exp_hit = 0;
		exp_miss = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		repeat (8) @(negedge clk_i);
		rst_ni = 1'b1;
		#(PERIOD / 4);

		err0 = errors;
		if (reg_wen_o !== 1'b0) begin
			$display("ERROR t=%0t reg_wen_o: got %b expected 0", $time, reg_wen_o);
			errors++;
		end
		if (stall_o !== 1'b0) begin
			$display("ERROR t=%0t stall_o: got %b expected 0", $time, stall_o);
			errors++;
		end
		if (no_acc_o !== '0) begin
			$display("ERROR t=%0t no_acc_o: got %0d expected 0", $time, no_acc_o);
			errors++;
		end
		if (no_hit_o !== '0) begin
			$display("ERROR t=%0t no_hit_o: got %0d expected 0", $time, no_hit_o);
			errors++;
		end
		if (no_miss_o !== '0) begin
			$display("ERROR t=%0t no_miss_o: got %0d expected 0", $time, no_miss_o);
			errors++;
		end
		report_test("reset", err0);

		// first store misses, the rest of the line then hits
		err0 = errors;
		run_access(32'h0000_0124, 1'b1, $urandom);
		run_access(32'h0000_0124, 1'b0, '0);
		run_access(32'h0000_0128, 1'b1, $urandom);
		run_access(32'h0000_0128, 1'b0, '0);
		run_access(32'h0000_0124, 1'b0, '0);
		drain_checks();
		report_test("store_load", err0);

		// six dirty lines on set 9, two more than the victim store holds
		err0 = errors;
		for (int t = 0; t < 6; t++) begin
			a = cache_pkg::addr_t'((t << 10) | (9 << 4) | ((t % 4) << 2));
			run_access(a, 1'b1, $urandom);
		end
		for (int pass = 0; pass < 2; pass++) begin
			for (int t = 0; t < 6; t++) begin
				a = cache_pkg::addr_t'((t << 10) | (9 << 4) | ((t % 4) << 2));
				run_access(a, 1'b0, '0);
			end
		end
		drain_checks();
		report_test("conflict", err0);

		// eight tags over four sets keeps hits and misses mixed
		err0 = errors;
		acc0 = exp_acc;
		hit0 = exp_hit;
		for (int n = 0; n < NUM_RANDOM; n++) begin
			a = cache_pkg::addr_t'((($urandom % 8) << 10) | (($urandom % 4) << 4) |
				(($urandom % 4) << 2));
			run_access(a, 1'($urandom), $urandom);
		end
		drain_checks();
		if (no_acc_o !== cache_pkg::word_t'(acc0 + NUM_RANDOM)) begin
			$display("ERROR t=%0t no_acc_o: got %0d expected %0d", $time, no_acc_o,
				acc0 + NUM_RANDOM);
			errors++;
		end
		if (no_hit_o !== cache_pkg::word_t'(exp_hit)) begin
			$display("ERROR t=%0t no_hit_o: got %0d expected %0d", $time, no_hit_o, exp_hit);
			errors++;
		end
		if (no_miss_o !== cache_pkg::word_t'(acc0 + NUM_RANDOM - exp_hit)) begin
			$display("ERROR t=%0t no_miss_o: got %0d expected %0d", $time, no_miss_o,
				acc0 + NUM_RANDOM - exp_hit);
			errors++;
		end
		$display("random run: %0d hits predicted of %0d", exp_hit - hit0, NUM_RANDOM);
		report_test("counters", err0);

		// bubble in, every field zero
		err0 = errors;
		@(negedge clk_i);
		drive_fields();
		flush_i = 1'b1;
		e = capture_expected();
		e.alu = '0;
		e.pc4 = '0;
		e.wb_sel = '0;
		e.reg_wen = 1'b0;
		e.rd = '0;
		e.inst = '0;
		e.chk_mem = 1'b1;
		@(posedge clk_i);
		exp_q.push_back(e);
		@(negedge clk_i);
		flush_i = 1'b0;
		drain_checks();
		report_test("flush", err0);

		// strobe on a missing line, dropped by the fetch stall
		err0 = errors;
		for (int n = 0; n < 4; n++) begin
			@(negedge clk_i);
			drive_fields();
			alu_i = 32'h0000_3ff0;
			mem_rw_i = 1'b0;
			mem_valid_i = 1'b1;
			icache_stall_i = 1'b1;
			e = capture_expected();
			#(PERIOD / 4);
			if (stall_o !== 1'b0) begin
				$display("ERROR t=%0t stall_o: got %b expected 0", $time, stall_o);
				errors++;
			end
			@(posedge clk_i);
			exp_q.push_back(e);
		end
		@(negedge clk_i);
		mem_valid_i = 1'b0;
		icache_stall_i = 1'b0;
		drain_checks();
		report_test("icache_stall", err0);

		$display("%0d tests, %0d passed, %0d failed, %0d check errors", tests_run,
			tests_run - tests_failed, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* files.f */
+incdir+.
cache_pkg.sv
main_memory.sv
victim_cache.sv
d_cache.sv
mem_stage.sv
mem_subsys_top.sv
tb_mem_subsys.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        = tb_mem_subsys
RTL_TOP    = mem_subsys_top
FILELIST   = files.f
OBJ_DIR    = obj_dir
BIN        = $(OBJ_DIR)/V$(TOP)
LOG        = sim.log
PASS_MSG   = TESTS PASSED
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing -Wno-fatal -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation result: pass"; \
	else \
		echo "simulation result: fail, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
